// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address width on the cpu and memory side
`define CACHE_ADDR_W 32

// word width of hrdata and mem_rdata
`define CACHE_DATA_W 32

// direct mapped, so one line per index
`define CACHE_LINES 16

// words fetched from memory per refill
`define CACHE_LINE_WORDS 4

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

    localparam int LINE_IDX_W = $clog2(`CACHE_LINES);
    localparam int WORD_OFF_W = $clog2(`CACHE_LINE_WORDS);
    // two byte bits sit below the word offset
    localparam int TAG_W = `CACHE_ADDR_W - LINE_IDX_W - WORD_OFF_W - 2;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } ahb_trans_t;

    typedef logic [LINE_IDX_W-1:0] line_idx_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;
    typedef logic [TAG_W-1:0]      tag_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_READ = 2'b01,
        ST_WAIT = 2'b10,
        ST_DONE = 2'b11
    } refill_state_t;

endpackage

// ==== verilog/ahb_read_port.sv ====
`timescale 1ns/1ns
`include "cache_cfg.svh"

module ahb_read_port
    import cache_pkg::*;
(
    input  logic                     cpu_intf,
    input  logic                     rst_n,
    input  logic [`CACHE_ADDR_W-1:0] haddr,
    input  ahb_trans_t               htrans,
    input  logic                     hit,
    input  logic [`CACHE_DATA_W-1:0] rd_data,
    input  logic                     refill_done,
    output logic                     hready,
    output logic [`CACHE_DATA_W-1:0] hrdata,
    output logic                     cache_hit,
    output logic                     lookup,
    output logic [`CACHE_ADDR_W-1:0] lookup_addr,
    output logic                     miss_req
);

    logic accept;
    logic retry_q;
    logic waiting_q;

    // address phase taken when the previous data phase completes
    assign accept = hready && (htrans == NONSEQ);

    // held address also serves the retry after a refill
    always_ff @(posedge cpu_intf) begin
        if (accept) begin
            lookup_addr <= haddr;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            lookup    <= 1'b0;
            retry_q   <= 1'b0;
            waiting_q <= 1'b0;
        end else begin
            lookup  <= accept || (waiting_q && refill_done);
            retry_q <= waiting_q && refill_done;
            if (miss_req) begin
                waiting_q <= 1'b1;
            end else if (refill_done) begin
                waiting_q <= 1'b0;
            end
        end
    end

    assign miss_req = lookup && !hit;

    // stretch the data phase from the missed lookup until the retry
    assign hready = !miss_req && !waiting_q;

    // store answers in the data phase cycle
    assign hrdata = rd_data;

    // the retry hits too, but the transfer itself was a miss
    assign cache_hit = lookup && hit && !retry_q;

    a_no_miss_while_pending: assert property (
        @(posedge cpu_intf) disable iff (!rst_n)
        miss_req |-> !waiting_q
    );

    // wait state must hold through the refill_done cycle
    a_stall_until_refill: assert property (
        @(posedge cpu_intf) disable iff (!rst_n)
        (miss_req || (waiting_q && !refill_done)) |=> !hready
    );

endmodule

// ==== verilog/cache_store.sv ====
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_store
    import cache_pkg::*;
(
    input  logic                     cpu_intf,
    input  logic                     rst_n,
    input  logic [`CACHE_ADDR_W-1:0] lookup_addr,
    input  logic                     fill_en,
    input  line_idx_t                fill_idx,
    input  word_off_t                fill_off,
    input  tag_t                     fill_tag,
    input  logic [`CACHE_DATA_W-1:0] fill_data,
    input  logic                     fill_last,
    output logic                     hit,
    output logic [`CACHE_DATA_W-1:0] rd_data
);

    logic [`CACHE_LINES-1:0]  valid_q;
    tag_t                     tag_mem [`CACHE_LINES];
    logic [`CACHE_DATA_W-1:0] data_mem [`CACHE_LINES][`CACHE_LINE_WORDS];

    tag_t      lk_tag;
    line_idx_t lk_idx;
    word_off_t lk_off;

    // fill tracking for the stability check
    logic      fill_open_q;
    line_idx_t open_idx_q;

    // address split: tag | index | word offset | byte
    assign lk_off = lookup_addr[WORD_OFF_W+1:2];
    assign lk_idx = lookup_addr[LINE_IDX_W+WORD_OFF_W+1:WORD_OFF_W+2];
    assign lk_tag = lookup_addr[`CACHE_ADDR_W-1:LINE_IDX_W+WORD_OFF_W+2];

    assign hit     = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign rd_data = data_mem[lk_idx][lk_off];

    // first word drops the valid bit, last word raises it again
    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_idx] <= fill_last;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fill_en) begin
            data_mem[fill_idx][fill_off] <= fill_data;
            if (fill_last) begin
                tag_mem[fill_idx] <= fill_tag;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            fill_open_q <= 1'b0;
        end else if (fill_en) begin
            fill_open_q <= !fill_last;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fill_en) begin
            open_idx_q <= fill_idx;
        end
    end

    // every word of one refill lands in the same line
    a_fill_idx_stable: assert property (
        @(posedge cpu_intf) disable iff (!rst_n)
        (fill_en && fill_open_q) |-> (fill_idx == open_idx_q)
    );

endmodule

// ==== verilog/line_refill.sv ====
`timescale 1ns/1ns
`include "cache_cfg.svh"

module line_refill
    import cache_pkg::*;
(
    input  logic                     cpu_intf,
    input  logic                     rst_n,
    input  logic                     miss_req,
    input  logic [`CACHE_ADDR_W-1:0] miss_addr,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata,
    input  logic                     mem_valid,
    output logic                     mem_rd,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     fill_en,
    output line_idx_t                fill_idx,
    output word_off_t                fill_off,
    output tag_t                     fill_tag,
    output logic [`CACHE_DATA_W-1:0] fill_data,
    output logic                     fill_last,
    output logic                     refill_done
);

    refill_state_t state_q;
    tag_t          tag_q;
    line_idx_t     idx_q;
    word_off_t     off_q;
    logic          last_word;

    assign last_word = (off_q == word_off_t'(`CACHE_LINE_WORDS - 1));

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (miss_req) state_q <= ST_READ;
                ST_READ: state_q <= ST_WAIT;
                ST_WAIT: begin
                    if (mem_valid) begin
                        state_q <= last_word ? ST_DONE : ST_READ;
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // line aligned start, offset steps once per returned word
    always_ff @(posedge cpu_intf) begin
        if ((state_q == ST_IDLE) && miss_req) begin
            tag_q <= miss_addr[`CACHE_ADDR_W-1:LINE_IDX_W+WORD_OFF_W+2];
            idx_q <= miss_addr[LINE_IDX_W+WORD_OFF_W+1:WORD_OFF_W+2];
            off_q <= '0;
        end else if (fill_en) begin
            off_q <= off_q + 1'b1;
        end
    end

    assign mem_rd   = (state_q == ST_READ);
    assign mem_addr = {tag_q, idx_q, off_q, 2'b00};

    // returned word goes straight into the store
    assign fill_en     = (state_q == ST_WAIT) && mem_valid;
    assign fill_idx    = idx_q;
    assign fill_off    = off_q;
    assign fill_tag    = tag_q;
    assign fill_data   = mem_rdata;
    assign fill_last   = fill_en && last_word;
    assign refill_done = (state_q == ST_DONE);

    a_no_stray_mem_valid: assert property (
        @(posedge cpu_intf) disable iff (!rst_n)
        (state_q == ST_IDLE) |-> !mem_valid
    );

endmodule

// ==== verilog/read_cache_top.sv ====
`timescale 1ns/1ns
`include "cache_cfg.svh"

module read_cache_top
    import cache_pkg::*;
(
    input  logic                     cpu_intf,
    input  logic                     rst_n,
    input  logic [`CACHE_ADDR_W-1:0] haddr,
    input  ahb_trans_t               htrans,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata,
    input  logic                     mem_valid,
    output logic                     hready,
    output logic [`CACHE_DATA_W-1:0] hrdata,
    output logic                     cache_hit,
    output logic                     mem_rd,
    output logic [`CACHE_ADDR_W-1:0] mem_addr
);

    logic [`CACHE_ADDR_W-1:0] lookup_addr;
    logic                     miss_req;
    logic                     hit;
    logic [`CACHE_DATA_W-1:0] rd_data;
    logic                     refill_done;

    logic                     fill_en;
    line_idx_t                fill_idx;
    word_off_t                fill_off;
    tag_t                     fill_tag;
    logic [`CACHE_DATA_W-1:0] fill_data;
    logic                     fill_last;

    ahb_read_port i_port (
        .cpu_intf    (cpu_intf),
        .rst_n       (rst_n),
        .haddr       (haddr),
        .htrans      (htrans),
        .hit         (hit),
        .rd_data     (rd_data),
        .refill_done (refill_done),
        .hready      (hready),
        .hrdata      (hrdata),
        .cache_hit   (cache_hit),
        .lookup      (),
        .lookup_addr (lookup_addr),
        .miss_req    (miss_req)
    );

    cache_store i_store (
        .cpu_intf    (cpu_intf),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_idx    (fill_idx),
        .fill_off    (fill_off),
        .fill_tag    (fill_tag),
        .fill_data   (fill_data),
        .fill_last   (fill_last),
        .hit         (hit),
        .rd_data     (rd_data)
    );

    // missed address is the port's held lookup address
    line_refill i_refill (
        .cpu_intf    (cpu_intf),
        .rst_n       (rst_n),
        .miss_req    (miss_req),
        .miss_addr   (lookup_addr),
        .mem_rdata   (mem_rdata),
        .mem_valid   (mem_valid),
        .mem_rd      (mem_rd),
        .mem_addr    (mem_addr),
        .fill_en     (fill_en),
        .fill_idx    (fill_idx),
        .fill_off    (fill_off),
        .fill_tag    (fill_tag),
        .fill_data   (fill_data),
        .fill_last   (fill_last),
        .refill_done (refill_done)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ns
`include "cache_cfg.svh"

module tb_mem_model #(
    parameter int SEED      = 1,
    parameter int MAX_DELAY = 6
) (
    input  logic                     cpu_intf,
    input  logic                     rst_n,
    input  logic                     mem_rd,
    input  logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic [`CACHE_DATA_W-1:0] mem_rdata,
    output logic                     mem_valid
);

    int                       seed;
    int                       delay;
    logic                     busy;
    logic [`CACHE_ADDR_W-1:0] req_addr;

    // one read outstanding, answer driven on the falling edge
    initial begin
        seed      = SEED;
        delay     = 0;
        busy      = 1'b0;
        req_addr  = '0;
        mem_valid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge cpu_intf);
            mem_valid = 1'b0;
            if (!rst_n) begin
                busy = 1'b0;
            end else if (busy) begin
                if (delay == 0) begin
                    // every word reads back as its inverted byte address
                    mem_rdata = ~req_addr;
                    mem_valid = 1'b1;
                    busy      = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end else if (mem_rd) begin
                req_addr = mem_addr;
                delay    = {$random(seed)} % MAX_DELAY;
                busy     = 1'b1;
            end
        end
    end

endmodule

// ==== sim/tb_read_cache.sv ====
`timescale 1ns/1ns
`include "cache_cfg.svh"

module tb_read_cache
    import cache_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int SEED          = 68027;
    localparam int NUM_READS     = 200;
    localparam int MEM_DELAY_MAX = 6;
    localparam int MAX_GAP       = 3;
    localparam int WINDOW_WORDS  = 64;
    localparam logic [`CACHE_ADDR_W-1:0] WINDOW_BASE = 32'hA00;
    // miss cycle, a read plus the longest wait per word, done and retry
    localparam int MISS_CYCLES   = 3 + `CACHE_LINE_WORDS * (MEM_DELAY_MAX + 1);
    localparam int WATCHDOG_NS   =
        2 * (RESET_CYCLES + 20 + NUM_READS * (MISS_CYCLES + MAX_GAP)) * CLK_PERIOD;

    logic                     cpu_intf;
    logic                     rst_n;
    logic [`CACHE_ADDR_W-1:0] haddr;
    ahb_trans_t               htrans;
    logic                     hready;
    logic [`CACHE_DATA_W-1:0] hrdata;
    logic                     cache_hit;
    logic                     mem_rd;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    logic [`CACHE_DATA_W-1:0] mem_rdata;
    logic                     mem_valid;

    int                       seed;
    logic                     test_end;

    // reference view of the bus and of which lines are resident
    logic                     dphase_q;
    logic                     accessed_q;
    logic                     exp_hit_q;
    logic [`CACHE_ADDR_W-1:0] acc_addr_q;
    int                       rd_cnt_q;
    int                       b2b_hits_q;
    logic [`CACHE_LINES-1:0]  line_valid;
    tag_t                     line_tag [`CACHE_LINES];

    read_cache_top i_dut (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .haddr     (haddr),
        .htrans    (htrans),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid),
        .hready    (hready),
        .hrdata    (hrdata),
        .cache_hit (cache_hit),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr)
    );

    tb_mem_model #(
        .SEED      (SEED),
        .MAX_DELAY (MEM_DELAY_MAX)
    ) i_mem (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid)
    );

    initial begin
        cpu_intf = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_intf = ~cpu_intf;
    end

    function automatic line_idx_t index_of(input logic [`CACHE_ADDR_W-1:0] addr);
        return addr[LINE_IDX_W+WORD_OFF_W+1:WORD_OFF_W+2];
    endfunction

    function automatic tag_t tag_of(input logic [`CACHE_ADDR_W-1:0] addr);
        return addr[`CACHE_ADDR_W-1:LINE_IDX_W+WORD_OFF_W+2];
    endfunction

    function automatic logic [`CACHE_ADDR_W-1:0] word_addr(
        input logic [`CACHE_ADDR_W-1:0] addr,
        input int                       word
    );
        return {addr[`CACHE_ADDR_W-1:WORD_OFF_W+2], word_off_t'(word), 2'b00};
    endfunction

    function automatic logic is_cached(input logic [`CACHE_ADDR_W-1:0] addr);
        return line_valid[index_of(addr)] && (line_tag[index_of(addr)] == tag_of(addr));
    endfunction

    always @(posedge cpu_intf) begin
        if (!rst_n) begin
            dphase_q   <= 1'b0;
            accessed_q <= 1'b0;
            exp_hit_q  <= 1'b0;
            rd_cnt_q   <= 0;
            b2b_hits_q <= 0;
            line_valid <= '0;
        end else begin
            if (mem_rd) begin
                rd_cnt_q <= rd_cnt_q + 1;
            end
            if (hready && (htrans == NONSEQ)) begin
                dphase_q   <= 1'b1;
                accessed_q <= 1'b1;
                acc_addr_q <= haddr;
                exp_hit_q  <= is_cached(haddr);
                rd_cnt_q   <= 0;
                line_valid[index_of(haddr)] <= 1'b1;
                line_tag[index_of(haddr)]   <= tag_of(haddr);
                if (dphase_q && exp_hit_q && is_cached(haddr)) begin
                    b2b_hits_q <= b2b_hits_q + 1;
                end
            end else if (hready) begin
                dphase_q <= 1'b0;
            end
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_value(
        input string                    name,
        input logic [`CACHE_ADDR_W-1:0] expected,
        input logic [`CACHE_ADDR_W-1:0] actual
    );
        $display("[ERROR] %0t: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %0t: %s", $time, what);
        abort_run();
    endtask

    a_idle_hready: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        !accessed_q |-> hready)
    else report_value("hready", 1, $sampled(hready));

    a_idle_hit: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        !accessed_q |-> !cache_hit)
    else report_value("cache_hit", 0, $sampled(cache_hit));

    a_idle_mem_rd: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        !accessed_q |-> !mem_rd)
    else report_value("mem_rd", 0, $sampled(mem_rd));

    a_hrdata: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (dphase_q && hready) |-> (hrdata == ~acc_addr_q))
    else report_value("hrdata", ~$sampled(acc_addr_q), $sampled(hrdata));

    a_miss_flag: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (dphase_q && !exp_hit_q) |-> !cache_hit)
    else report_value("cache_hit", 0, $sampled(cache_hit));

    a_miss_reads: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (dphase_q && !exp_hit_q && hready) |-> (rd_cnt_q == `CACHE_LINE_WORDS))
    else report_value("mem_rd count", `CACHE_LINE_WORDS, $sampled(rd_cnt_q));

    a_mem_rd_in_miss: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        mem_rd |-> (dphase_q && !exp_hit_q))
    else report_failure("memory read issued outside the data phase of a miss");

    a_mem_addr: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        mem_rd |-> (mem_addr == word_addr(acc_addr_q, rd_cnt_q)))
    else report_value("mem_addr", word_addr($sampled(acc_addr_q), $sampled(rd_cnt_q)),
        $sampled(mem_addr));

    a_hit_ready: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (dphase_q && exp_hit_q) |-> hready)
    else report_value("hready", 1, $sampled(hready));

    a_hit_flag: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (dphase_q && exp_hit_q) |-> cache_hit)
    else report_value("cache_hit", 1, $sampled(cache_hit));

    a_b2b_reached: assert property (@(posedge cpu_intf) disable iff (!rst_n)
        test_end |-> (b2b_hits_q > 0))
    else report_failure("stimulus never produced back-to-back hits");

    // address phase holds until the next rising edge with hready high
    task automatic read_word(input logic [`CACHE_ADDR_W-1:0] addr);
        haddr  = addr;
        htrans = NONSEQ;
        while (!hready) @(negedge cpu_intf);
        @(negedge cpu_intf);
    endtask

    task automatic idle_gap(input int cycles);
        htrans = IDLE;
        repeat (cycles) @(negedge cpu_intf);
    endtask

    task automatic finish_transfers();
        htrans = IDLE;
        while (!hready) @(negedge cpu_intf);
        @(negedge cpu_intf);
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired, reads did not complete and the DUT looks hung");
    end

    initial begin
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_ADDR_W-1:0] history [$];
        int                       pick;
        seed     = SEED;
        rst_n    = 1'b0;
        haddr    = '0;
        htrans   = IDLE;
        test_end = 1'b0;
        repeat (RESET_CYCLES) @(negedge cpu_intf);
        rst_n = 1'b1;
        repeat (3) @(negedge cpu_intf);

        // one line miss, then its other words back to back
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            read_word(32'hA40 + w * 4);
        end
        idle_gap(2);

        for (int n = 0; n < NUM_READS - `CACHE_LINE_WORDS; n++) begin
            if ((history.size() > 0) && (({$random(seed)} % 2) == 1)) begin
                pick = {$random(seed)} % history.size();
                addr = history[pick];
            end else begin
                addr = WINDOW_BASE + ({$random(seed)} % WINDOW_WORDS) * 4;
            end
            history.push_back(addr);
            read_word(addr);
            if (({$random(seed)} % 4) == 0) begin
                idle_gap(1 + {$random(seed)} % MAX_GAP);
            end
        end
        finish_transfers();

        test_end = 1'b1;
        @(negedge cpu_intf);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
verilog/cache_pkg.sv
verilog/ahb_read_port.sv
verilog/cache_store.sv
verilog/line_refill.sv
verilog/read_cache_top.sv
sim/tb_mem_model.sv
sim/tb_read_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_read_cache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
